/* verilog/regress_params.svh */
`ifndef REGRESS_PARAMS_SVH
`define REGRESS_PARAMS_SVH

// ---------------------------------------------------------------------------
// fixed-point word layout, signed Q16.16
// ---------------------------------------------------------------------------
// total bits in one fx word
`define FX_WIDTH 32
// bits right of the binary point
`define FX_QFRAC 16

// sample counter, sets up to 65535 samples
`define CNT_WIDTH 16

`endif

/* verilog/fx_pkg.sv */
`default_nettype none

`include "regress_params.svh"

package fx_pkg;

  // ---------------------------------------------------------------------------
  // fixed-point number types
  // ---------------------------------------------------------------------------
  // one signed Q word
  typedef logic signed [`FX_WIDTH-1:0] fx_word_t;
  // double width, holds a full product or a pre-shifted dividend
  typedef logic signed [2*`FX_WIDTH-1:0] fx_wide_t;

  // saturation limits of fx_word_t
  localparam fx_word_t fx_max = {1'b0, {(`FX_WIDTH-1){1'b1}}};
  localparam fx_word_t fx_min = {1'b1, {(`FX_WIDTH-1){1'b0}}};

  // 1.0 in Q format, expected on a normalized diagonal
  // and added to the N sum per sample
  localparam fx_word_t fx_one = fx_word_t'(1) <<< `FX_QFRAC;

endpackage

`default_nettype wire

/* verilog/regress_pkg.sv */
`default_nettype none

`include "regress_params.svh"

package regress_pkg;

  import fx_pkg::*;

  // ---------------------------------------------------------------------------
  // regression-level types
  // ---------------------------------------------------------------------------
  // number of samples in one set, wraps past 2**CNT_WIDTH-1
  typedef logic [`CNT_WIDTH-1:0] sample_cnt_t;

  // one row of the augmented system
  // [0..2] coefficients of b0, b1, b2
  // [3]    right-hand side
  typedef fx_word_t fx_row_t [0:3];

  // the elimination keeps this layout through all seven stages,
  // back-substitution only reads the upper triangle and column 3

endpackage

`default_nettype wire

/* verilog/fx_mul.sv */
`timescale 1ns/10ps
`default_nettype none

`include "regress_params.svh"

module fx_mul
  import fx_pkg::*;
(
  input  fx_word_t a,
  input  fx_word_t b,
  output fx_word_t result
);

  // half an output LSB, the rounding increment
  localparam fx_wide_t half_lsb = fx_wide_t'(1) <<< (`FX_QFRAC - 1);

  fx_wide_t prod;
  fx_wide_t prod_mag;
  fx_wide_t mag_rnd;
  fx_wide_t scaled;

  always_comb begin
    // full product, cannot overflow the wide word
    prod     = fx_wide_t'(a) * fx_wide_t'(b);
    // round the magnitude so ties go away from zero
    prod_mag = prod[2*`FX_WIDTH-1] ? -prod : prod;
    mag_rnd  = (prod_mag + half_lsb) >>> `FX_QFRAC;
    scaled   = prod[2*`FX_WIDTH-1] ? -mag_rnd : mag_rnd;
    // clamp to the word range
    if (scaled > fx_wide_t'(fx_max)) begin
      result = fx_max;
    end else if (scaled < fx_wide_t'(fx_min)) begin
      result = fx_min;
    end else begin
      result = scaled[`FX_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

/* verilog/fx_div.sv */
`timescale 1ns/10ps
`default_nettype none

`include "regress_params.svh"

module fx_div
  import fx_pkg::*;
(
  input  fx_word_t num,
  input  fx_word_t denom,
  output fx_word_t result
);

  fx_wide_t dividend;
  fx_wide_t quotient;
  logic     denom_zero;

  // ---------------------------------------------------------------------------
  // (num << QFRAC) / denom, truncated toward zero
  // ---------------------------------------------------------------------------
  assign denom_zero = (denom == '0);

  always_comb begin
    // pre-shift keeps the quotient in Q format
    dividend = fx_wide_t'(num) <<< `FX_QFRAC;
    quotient = '0;
    if (denom_zero) begin
      // no X out of the divider, largest value with the sign of num
      result = num[`FX_WIDTH-1] ? fx_min : fx_max;
    end else begin
      quotient = dividend / fx_wide_t'(denom);
      // small denominators blow past the word range
      if (quotient > fx_wide_t'(fx_max)) begin
        result = fx_max;
      end else if (quotient < fx_wide_t'(fx_min)) begin
        result = fx_min;
      end else begin
        result = quotient[`FX_WIDTH-1:0];
      end
    end
  end

  // a pivot of zero is caught downstream through the
  // normalized diagonal, which then reads fx_max instead of 1.0

endmodule

`default_nettype wire

/* verilog/normal_eq_accum.sv */
`timescale 1ns/10ps
`default_nettype none

module normal_eq_accum
  import fx_pkg::*;
  import regress_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        sample_valid,
  input  logic        sample_last,
  input  fx_word_t    x1,
  input  fx_word_t    x2,
  input  fx_word_t    y,
  output logic        sys_valid,
  output fx_word_t    sys_a [9],
  output fx_word_t    sys_b [3],
  output sample_cnt_t sys_count
);

  // ---------------------------------------------------------------------------
  // per-sample products
  // ---------------------------------------------------------------------------
  fx_word_t p_x1x1;
  fx_word_t p_x2x2;
  fx_word_t p_x1x2;
  fx_word_t p_x1y;
  fx_word_t p_x2y;

  fx_mul u_mul_x1x1 (.a(x1), .b(x1), .result(p_x1x1));
  fx_mul u_mul_x2x2 (.a(x2), .b(x2), .result(p_x2x2));
  fx_mul u_mul_x1x2 (.a(x1), .b(x2), .result(p_x1x2));
  fx_mul u_mul_x1y  (.a(x1), .b(y),  .result(p_x1y));
  fx_mul u_mul_x2y  (.a(x2), .b(y),  .result(p_x2y));

  // ---------------------------------------------------------------------------
  // running sums, wrap on overflow
  // ---------------------------------------------------------------------------
  // N in Q format, grows by 1.0 per sample
  fx_word_t    sum_n;
  fx_word_t    sum_x1;
  fx_word_t    sum_x2;
  fx_word_t    sum_x1x1;
  fx_word_t    sum_x2x2;
  fx_word_t    sum_x1x2;
  fx_word_t    sum_y;
  fx_word_t    sum_x1y;
  fx_word_t    sum_x2y;
  sample_cnt_t cnt;

  // sums including the sample on the input now
  fx_word_t    nxt_n;
  fx_word_t    nxt_x1;
  fx_word_t    nxt_x2;
  fx_word_t    nxt_x1x1;
  fx_word_t    nxt_x2x2;
  fx_word_t    nxt_x1x2;
  fx_word_t    nxt_y;
  fx_word_t    nxt_x1y;
  fx_word_t    nxt_x2y;
  sample_cnt_t nxt_cnt;

  assign nxt_n    = sum_n + fx_one;
  assign nxt_x1   = sum_x1 + x1;
  assign nxt_x2   = sum_x2 + x2;
  assign nxt_x1x1 = sum_x1x1 + p_x1x1;
  assign nxt_x2x2 = sum_x2x2 + p_x2x2;
  assign nxt_x1x2 = sum_x1x2 + p_x1x2;
  assign nxt_y    = sum_y + y;
  assign nxt_x1y  = sum_x1y + p_x1y;
  assign nxt_x2y  = sum_x2y + p_x2y;
  assign nxt_cnt  = cnt + sample_cnt_t'(1);

  // last sample clears the sums on the same edge, next set may follow at once
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sys_valid <= 1'b0;
      sum_n     <= '0;
      sum_x1    <= '0;
      sum_x2    <= '0;
      sum_x1x1  <= '0;
      sum_x2x2  <= '0;
      sum_x1x2  <= '0;
      sum_y     <= '0;
      sum_x1y   <= '0;
      sum_x2y   <= '0;
      cnt       <= '0;
    end else begin
      sys_valid <= sample_valid & sample_last;
      if (sample_valid) begin
        sum_n    <= sample_last ? '0 : nxt_n;
        sum_x1   <= sample_last ? '0 : nxt_x1;
        sum_x2   <= sample_last ? '0 : nxt_x2;
        sum_x1x1 <= sample_last ? '0 : nxt_x1x1;
        sum_x2x2 <= sample_last ? '0 : nxt_x2x2;
        sum_x1x2 <= sample_last ? '0 : nxt_x1x2;
        sum_y    <= sample_last ? '0 : nxt_y;
        sum_x1y  <= sample_last ? '0 : nxt_x1y;
        sum_x2y  <= sample_last ? '0 : nxt_x2y;
        cnt      <= sample_last ? '0 : nxt_cnt;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // symmetric system, row-major, captured on the closing sample
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (sample_valid && sample_last) begin
      sys_a[0]  <= nxt_n;
      sys_a[1]  <= nxt_x1;
      sys_a[2]  <= nxt_x2;
      sys_a[3]  <= nxt_x1;
      sys_a[4]  <= nxt_x1x1;
      sys_a[5]  <= nxt_x1x2;
      sys_a[6]  <= nxt_x2;
      sys_a[7]  <= nxt_x1x2;
      sys_a[8]  <= nxt_x2x2;
      sys_b[0]  <= nxt_y;
      sys_b[1]  <= nxt_x1y;
      sys_b[2]  <= nxt_x2y;
      sys_count <= nxt_cnt;
    end
  end

  // an unknown strobe would smear X into every sum
  a_sample_valid_known : assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(sample_valid)
  );

endmodule

`default_nettype wire

/* verilog/gauss_eliminate_3x3.sv */
`timescale 1ns/10ps
`default_nettype none

`include "regress_params.svh"

module gauss_eliminate_3x3
  import fx_pkg::*;
  import regress_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        sys_valid,
  input  fx_word_t    sys_a [9],
  input  fx_word_t    sys_b [3],
  input  sample_cnt_t sys_count,
  output logic        tri_valid,
  output fx_row_t     tri_rows [3],
  output sample_cnt_t tri_count
);

  // magnitude as unsigned, so fx_min compares as 2**31
  function automatic logic [`FX_WIDTH-1:0] fx_abs(input fx_word_t v);
    fx_abs = v[`FX_WIDTH-1] ? -v : v;
  endfunction

  // ---------------------------------------------------------------------------
  // valid and count ride along with the matrix
  // ---------------------------------------------------------------------------
  logic [7:1]  v_q;
  sample_cnt_t cnt_q [1:7];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v_q <= '0;
    end else begin
      v_q <= {v_q[6:1], sys_valid};
    end
  end

  always_ff @(posedge clk) begin
    cnt_q[1] <= sys_count;
    for (int s = 2; s <= 7; s++) begin
      cnt_q[s] <= cnt_q[s-1];
    end
  end

  assign tri_valid = v_q[7];
  assign tri_count = cnt_q[7];

  // stage 1, augmented matrix [A | B]
  fx_row_t m1 [3];

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        m1[i][j] <= sys_a[i*3+j];
      end
      m1[i][3] <= sys_b[i];
    end
  end

  // stage 2, largest |col 0| moves to row 0
  fx_row_t    m2 [3];
  logic [1:0] piv0;

  always_comb begin
    piv0 = 2'd0;
    // strict compare, ties keep the lower row
    if (fx_abs(m1[1][0]) > fx_abs(m1[0][0])) begin
      piv0 = 2'd1;
    end
    if (fx_abs(m1[2][0]) > fx_abs(m1[piv0][0])) begin
      piv0 = 2'd2;
    end
  end

  always_ff @(posedge clk) begin
    m2[0] <= m1[piv0];
    m2[1] <= m1[1];
    m2[2] <= m1[2];
    if (piv0 == 2'd1) begin
      m2[1] <= m1[0];
    end
    if (piv0 == 2'd2) begin
      m2[2] <= m1[0];
    end
  end

  // stage 3, row 0 divided by its pivot
  fx_row_t m3 [3];
  fx_row_t norm0_q;

  for (genvar j = 0; j < 4; j++) begin : g_norm0
    fx_div u_div (.num(m2[0][j]), .denom(m2[0][0]), .result(norm0_q[j]));
  end

  always_ff @(posedge clk) begin
    m3[0] <= norm0_q;
    m3[1] <= m2[1];
    m3[2] <= m2[2];
  end

  // stage 4, row r minus m3[r][0] times row 0
  fx_row_t m4 [3];
  fx_row_t elim0_p [1:2];

  for (genvar r = 1; r < 3; r++) begin : g_elim0_row
    for (genvar c = 0; c < 4; c++) begin : g_elim0_col
      fx_mul u_mul (.a(m3[r][0]), .b(m3[0][c]), .result(elim0_p[r][c]));
    end
  end

  always_ff @(posedge clk) begin
    m4[0] <= m3[0];
    for (int r = 1; r < 3; r++) begin
      for (int c = 0; c < 4; c++) begin
        m4[r][c] <= m3[r][c] - elim0_p[r][c];
      end
    end
  end

  // stage 5, larger |col 1| of rows 1 and 2 becomes row 1
  fx_row_t m5 [3];
  logic    piv1_swap;

  assign piv1_swap = fx_abs(m4[2][1]) > fx_abs(m4[1][1]);

  always_ff @(posedge clk) begin
    m5[0] <= m4[0];
    if (piv1_swap) begin
      m5[1] <= m4[2];
      m5[2] <= m4[1];
    end else begin
      m5[1] <= m4[1];
      m5[2] <= m4[2];
    end
  end

  // stage 6, row 1 divided by its pivot, col 0 is already zero
  fx_row_t  m6 [3];
  fx_word_t norm1_q [1:3];

  for (genvar j = 1; j < 4; j++) begin : g_norm1
    fx_div u_div (.num(m5[1][j]), .denom(m5[1][1]), .result(norm1_q[j]));
  end

  always_ff @(posedge clk) begin
    m6[0]    <= m5[0];
    m6[2]    <= m5[2];
    m6[1][0] <= m5[1][0];
    for (int j = 1; j < 4; j++) begin
      m6[1][j] <= norm1_q[j];
    end
  end

  // stage 7, clear col 1 of row 2, result is the triangle
  fx_word_t elim1_p [1:3];

  for (genvar j = 1; j < 4; j++) begin : g_elim1
    fx_mul u_mul (.a(m6[2][1]), .b(m6[1][j]), .result(elim1_p[j]));
  end

  always_ff @(posedge clk) begin
    tri_rows[0]    <= m6[0];
    tri_rows[1]    <= m6[1];
    tri_rows[2][0] <= m6[2][0];
    for (int j = 1; j < 4; j++) begin
      tri_rows[2][j] <= m6[2][j] - elim1_p[j];
    end
  end

  // the input strobe and all seven stage valids stay known
  a_stage_valid_known : assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown({v_q, sys_valid})
  );

endmodule

`default_nettype wire

/* verilog/back_substitute_3x3.sv */
`timescale 1ns/10ps
`default_nettype none

module back_substitute_3x3
  import fx_pkg::*;
  import regress_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        tri_valid,
  input  fx_row_t     tri_rows [3],
  input  sample_cnt_t tri_count,
  output logic        beta_valid,
  output fx_word_t    beta [3],
  output logic        beta_singular,
  output sample_cnt_t beta_count
);

  // ---------------------------------------------------------------------------
  // control, valid and singular flag per stage
  // ---------------------------------------------------------------------------
  logic [3:1] v_q;
  logic [2:1] sing_q;
  logic       sing_in;

  // zero last pivot, or a unit diagonal that did not come out as 1.0
  assign sing_in = (tri_rows[2][2] == '0) || (tri_rows[0][0] != fx_one) ||
                   (tri_rows[1][1] != fx_one);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v_q           <= '0;
      sing_q        <= '0;
      beta_singular <= 1'b0;
    end else begin
      v_q           <= {v_q[2:1], tri_valid};
      sing_q        <= {sing_q[1], sing_in};
      beta_singular <= sing_q[2];
    end
  end

  assign beta_valid = v_q[3];

  // stage 1, b2 = rhs2 / a22
  fx_word_t    b2_div;
  fx_row_t     row0_s1;
  fx_row_t     row1_s1;
  fx_word_t    b2_s1;
  sample_cnt_t cnt_s1;

  fx_div u_div_b2 (.num(tri_rows[2][3]), .denom(tri_rows[2][2]), .result(b2_div));

  always_ff @(posedge clk) begin
    row0_s1 <= tri_rows[0];
    row1_s1 <= tri_rows[1];
    b2_s1   <= b2_div;
    cnt_s1  <= tri_count;
  end

  // stage 2, b1 = rhs1 - a12*b2, a11 is 1.0
  fx_word_t    p_a12;
  fx_row_t     row0_s2;
  fx_word_t    b2_s2;
  fx_word_t    b1_s2;
  sample_cnt_t cnt_s2;

  fx_mul u_mul_a12 (.a(row1_s1[2]), .b(b2_s1), .result(p_a12));

  always_ff @(posedge clk) begin
    row0_s2 <= row0_s1;
    b2_s2   <= b2_s1;
    b1_s2   <= row1_s1[3] - p_a12;
    cnt_s2  <= cnt_s1;
  end

  // stage 3, b0 = rhs0 - a01*b1 - a02*b2
  fx_word_t p_a01;
  fx_word_t p_a02;

  fx_mul u_mul_a01 (.a(row0_s2[1]), .b(b1_s2), .result(p_a01));
  fx_mul u_mul_a02 (.a(row0_s2[2]), .b(b2_s2), .result(p_a02));

  always_ff @(posedge clk) begin
    beta[0]    <= row0_s2[3] - p_a01 - p_a02;
    beta[1]    <= b1_s2;
    beta[2]    <= b2_s2;
    beta_count <= cnt_s2;
  end

  // dividers saturate on zero, so even a singular set leaves no X
  a_beta_known : assert property (
    @(posedge clk) disable iff (!rst_n)
      beta_valid |-> !$isunknown({beta[0], beta[1], beta[2]})
  );

endmodule

`default_nettype wire

/* verilog/regress_top.sv */
`timescale 1ns/10ps
`default_nettype none

module regress_top
  import fx_pkg::*;
  import regress_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        sample_valid,
  input  logic        sample_last,
  input  fx_word_t    x1,
  input  fx_word_t    x2,
  input  fx_word_t    y,
  output logic        beta_valid,
  output fx_word_t    beta [3],
  output logic        beta_singular,
  output sample_cnt_t beta_count
);

  // ---------------------------------------------------------------------------
  // accumulate 1 cycle, eliminate 7, back-substitute 3
  // ---------------------------------------------------------------------------
  logic        sys_valid;
  fx_word_t    sys_a [9];
  fx_word_t    sys_b [3];
  sample_cnt_t sys_count;

  logic        tri_valid;
  fx_row_t     tri_rows [3];
  sample_cnt_t tri_count;

  normal_eq_accum u_accum (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .sample_last  (sample_last),
    .x1           (x1),
    .x2           (x2),
    .y            (y),
    .sys_valid    (sys_valid),
    .sys_a        (sys_a),
    .sys_b        (sys_b),
    .sys_count    (sys_count)
  );

  gauss_eliminate_3x3 u_gauss (
    .clk       (clk),
    .rst_n     (rst_n),
    .sys_valid (sys_valid),
    .sys_a     (sys_a),
    .sys_b     (sys_b),
    .sys_count (sys_count),
    .tri_valid (tri_valid),
    .tri_rows  (tri_rows),
    .tri_count (tri_count)
  );

  back_substitute_3x3 u_backsub (
    .clk           (clk),
    .rst_n         (rst_n),
    .tri_valid     (tri_valid),
    .tri_rows      (tri_rows),
    .tri_count     (tri_count),
    .beta_valid    (beta_valid),
    .beta          (beta),
    .beta_singular (beta_singular),
    .beta_count    (beta_count)
  );

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
  input  logic force_reset,
  output logic clk,
  output logic rst_n
);

  // half of the 40 ns period
  localparam int half_period_ns = 20;

  logic por_n;

  initial clk = 1'b0;
  always #half_period_ns clk = ~clk;

  // power-on reset covers two rising edges, released on a falling edge
  initial begin
    por_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    por_n = 1'b1;
  end

  // force_reset lets a test pull reset in the middle of the run
  assign rst_n = por_n & ~force_reset;

endmodule

`default_nettype wire

/* tb/tb_regress.sv */
`timescale 1ns/10ps
`default_nettype none

`include "regress_params.svh"

module tb_regress
  import fx_pkg::*;
  import regress_pkg::*;
();

  // ---------------------------------------------------------------------------
  // run limits and tolerances
  // ---------------------------------------------------------------------------
  // full sets sent over the whole run
  localparam int num_sets        = 9;
  localparam int watchdog_cycles = 200 * num_sets + 500;
  localparam int clk_period_ns   = 40;
  localparam int tol_lsb         = 256;
  // edge that samples the last strobe to the edge that samples beta_valid
  localparam int pipe_latency    = 11;
  // cycles allowed per awaited result
  localparam int result_wait     = 100;

  logic        clk;
  logic        rst_n;
  logic        force_reset;
  logic        sample_valid;
  logic        sample_last;
  fx_word_t    x1;
  fx_word_t    x2;
  fx_word_t    y;
  logic        beta_valid;
  fx_word_t    beta [3];
  logic        beta_singular;
  sample_cnt_t beta_count;

  int mismatch_count = 0;
  int other_count    = 0;
  int cyc            = 0;

  // results seen at the output, in arrival order
  fx_word_t    got_b0 [$];
  fx_word_t    got_b1 [$];
  fx_word_t    got_b2 [$];
  logic        got_sing [$];
  sample_cnt_t got_cnt [$];
  int          got_cyc [$];
  // edge numbers that sampled each closing strobe
  int          last_cyc [$];

  // sample buffer for the next set
  int       stim_x1 [16];
  int       stim_x2 [16];
  fx_word_t stim_y [16];
  int       stim_n;

  // centered, uncorrelated grid with distinct values per column
  int grid_x1 [8] = '{-4, -3, -2, -1, 1, 2, 3, 4};
  int grid_x2 [8] = '{1, -2, 3, -4, 4, -3, 2, -1};

  tb_clkgen u_clkgen (
    .force_reset (force_reset),
    .clk         (clk),
    .rst_n       (rst_n)
  );

  regress_top u_regress_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample_valid  (sample_valid),
    .sample_last   (sample_last),
    .x1            (x1),
    .x2            (x2),
    .y             (y),
    .beta_valid    (beta_valid),
    .beta          (beta),
    .beta_singular (beta_singular),
    .beta_count    (beta_count)
  );

  always @(posedge clk) cyc <= cyc + 1;

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (rst_n && beta_valid) begin
      got_b0.push_back(beta[0]);
      got_b1.push_back(beta[1]);
      got_b2.push_back(beta[2]);
      got_sing.push_back(beta_singular);
      got_cnt.push_back(beta_count);
      got_cyc.push_back(cyc + 1);
    end
  end

  // ---------------------------------------------------------------------------
  // number conversion and compare tasks
  // ---------------------------------------------------------------------------
  function automatic fx_word_t fx_of_int(input int v);
    fx_of_int = fx_word_t'(v) <<< `FX_QFRAC;
  endfunction

  // quarter steps cover every coefficient used here
  function automatic fx_word_t fx_of_quarters(input int q);
    fx_of_quarters = fx_word_t'(q) <<< (`FX_QFRAC - 2);
  endfunction

  task automatic check_beta(input fx_word_t got, input fx_word_t exp, input string what);
    longint diff;
    diff = longint'(got) - longint'(exp);
    if (diff < 0) begin
      diff = -diff;
    end
    if (diff > tol_lsb) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %0d, expected %0d within %0d LSB",
               $time, what, got, exp, tol_lsb);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input sample_cnt_t got, input sample_cnt_t exp,
                             input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_latency(input int got, input int exp, input string what);
    if (got != exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  task automatic drive_sample(input fx_word_t sx1, input fx_word_t sx2, input fx_word_t sy,
                              input logic last);
    @(negedge clk);
    sample_valid = 1'b1;
    sample_last  = last;
    x1           = sx1;
    x2           = sx2;
    y            = sy;
    // the next rising edge samples this strobe
    if (last) begin
      last_cyc.push_back(cyc + 1);
    end
  endtask

  task automatic go_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      sample_valid = 1'b0;
      sample_last  = 1'b0;
    end
  endtask

  // y = c0 + c1*x1 + c2*x2, coefficients in quarters
  task automatic put_point(inout int k, input int v1, input int v2,
                           input int c0q, input int c1q, input int c2q);
    stim_x1[k] = v1;
    stim_x2[k] = v2;
    stim_y[k]  = fx_of_quarters(c0q + c1q * v1 + c2q * v2);
    k++;
  endtask

  // one strobe per cycle, no gaps, last flag on the final sample
  task automatic send_set();
    for (int i = 0; i < stim_n; i++) begin
      drive_sample(fx_of_int(stim_x1[i]), fx_of_int(stim_x2[i]), stim_y[i],
                   (i == stim_n - 1));
    end
  endtask

  // sums of x1, x2 and x1*x2 all zero, so the system is diagonal
  task automatic fill_balanced_set(input int n, input int c0, input int c1, input int c2);
    int k;
    int a;
    int b;
    int left;
    k = 0;
    a = 1 + int'($urandom % 3);
    b = 1 + int'($urandom % 3);
    put_point(k, a, b, 4 * c0, 4 * c1, 4 * c2);
    put_point(k, a, -b, 4 * c0, 4 * c1, 4 * c2);
    put_point(k, -a, b, 4 * c0, 4 * c1, 4 * c2);
    put_point(k, -a, -b, 4 * c0, 4 * c1, 4 * c2);
    left = n - 4;
    // mirrored pairs on each axis keep the sums at zero
    if (left >= 2) begin
      a = 1 + int'($urandom % 3);
      put_point(k, a, 0, 4 * c0, 4 * c1, 4 * c2);
      put_point(k, -a, 0, 4 * c0, 4 * c1, 4 * c2);
      left -= 2;
    end
    if (left >= 2) begin
      b = 1 + int'($urandom % 3);
      put_point(k, 0, b, 4 * c0, 4 * c1, 4 * c2);
      put_point(k, 0, -b, 4 * c0, 4 * c1, 4 * c2);
      left -= 2;
    end
    if (left == 1) begin
      put_point(k, 0, 0, 4 * c0, 4 * c1, 4 * c2);
    end
    stim_n = k;
  endtask

  // ---------------------------------------------------------------------------
  // result collection
  // ---------------------------------------------------------------------------
  task automatic await_results(input int count);
    int waited;
    waited = 0;
    while (got_b0.size() < count && waited < result_wait * count) begin
      @(negedge clk);
      waited++;
    end
    if (got_b0.size() < count) begin
      other_count++;
      $display("ERROR at %0t: only %0d of %0d results arrived in time",
               $time, got_b0.size(), count);
    end
  endtask

  task automatic pop_and_compare(input fx_word_t e0, input fx_word_t e1, input fx_word_t e2,
                                 input logic e_sing, input logic with_coefs,
                                 input sample_cnt_t e_cnt, input string name);
    fx_word_t    g0;
    fx_word_t    g1;
    fx_word_t    g2;
    logic        g_sing;
    sample_cnt_t g_cnt;
    int          g_cyc;
    int          l_cyc;
    if (got_b0.size() == 0 || last_cyc.size() == 0) begin
      other_count++;
      $display("ERROR at %0t: no result left to compare for %s", $time, name);
    end else begin
      g0     = got_b0.pop_front();
      g1     = got_b1.pop_front();
      g2     = got_b2.pop_front();
      g_sing = got_sing.pop_front();
      g_cnt  = got_cnt.pop_front();
      g_cyc  = got_cyc.pop_front();
      l_cyc  = last_cyc.pop_front();
      check_count(g_cnt, e_cnt, {name, " count"});
      check_flag(g_sing, e_sing, {name, " singular"});
      if (with_coefs) begin
        check_beta(g0, e0, {name, " b0"});
        check_beta(g1, e1, {name, " b1"});
        check_beta(g2, e2, {name, " b2"});
      end
      compare_latency(g_cyc - l_cyc, pipe_latency, {name, " latency"});
    end
  endtask

  // ---------------------------------------------------------------------------
  // directed tests
  // ---------------------------------------------------------------------------
  // y = 3 + 2*x1 - x2 over eight points
  task automatic exact_fit();
    int k;
    k = 0;
    for (int i = 0; i < 8; i++) begin
      put_point(k, grid_x1[i], grid_x2[i], 12, 8, -4);
    end
    stim_n = k;
    send_set();
    go_idle(1);
    await_results(1);
    pop_and_compare(fx_of_int(3), fx_of_int(2), fx_of_int(-1), 1'b0, 1'b1,
                    sample_cnt_t'(8), "exact fit");
  endtask

  // N = 4 against sum x1 = 8 forces the first swap,
  // after column 0 the row 2 pivot is -4 against -2, forcing the second
  task automatic pivot_swaps();
    int k;
    k = 0;
    // y = 0.5 - 1.25*x1 + 0.75*x2
    put_point(k, 1, 0, 2, -5, 3);
    put_point(k, 1, 3, 2, -5, 3);
    put_point(k, 3, 0, 2, -5, 3);
    put_point(k, 3, 1, 2, -5, 3);
    stim_n = k;
    send_set();
    go_idle(1);
    await_results(1);
    pop_and_compare(fx_of_quarters(2), fx_of_quarters(-5), fx_of_quarters(3), 1'b0, 1'b1,
                    sample_cnt_t'(4), "pivoting");
  endtask

  // x2 equal to x1, the columns are dependent
  task automatic singular_set();
    int k;
    k = 0;
    for (int i = 1; i <= 4; i++) begin
      put_point(k, i, i, 4, 4, 0);
    end
    stim_n = k;
    send_set();
    go_idle(1);
    await_results(1);
    pop_and_compare('0, '0, '0, 1'b1, 1'b0, sample_cnt_t'(4), "singular set");
  endtask

  // four sets with no idle cycle between them
  task automatic back_to_back_sets();
    int cf [4][3];
    int ns [4];
    for (int s = 0; s < 4; s++) begin
      ns[s] = 5 + int'($urandom % 5);
      for (int j = 0; j < 3; j++) begin
        cf[s][j] = int'($urandom % 11) - 5;
      end
      fill_balanced_set(ns[s], cf[s][0], cf[s][1], cf[s][2]);
      send_set();
    end
    go_idle(1);
    await_results(4);
    for (int s = 0; s < 4; s++) begin
      pop_and_compare(fx_of_int(cf[s][0]), fx_of_int(cf[s][1]), fx_of_int(cf[s][2]),
                      1'b0, 1'b1, sample_cnt_t'(ns[s]), $sformatf("back-to-back set %0d", s));
    end
  endtask

  task automatic reset_mid_set();
    int k;
    // a closed set whose result is still inside the pipeline at reset
    for (int i = 0; i < 3; i++) begin
      drive_sample(fx_of_int(i + 1), fx_of_int(i * i), fx_of_int(5), (i == 2));
    end
    // large stale samples, they would spoil the next fit if the sums survived
    for (int i = 0; i < 3; i++) begin
      drive_sample(fx_of_int(7), fx_of_int(-6), fx_of_int(50), 1'b0);
    end
    @(negedge clk);
    sample_valid = 1'b0;
    force_reset  = 1'b1;
    repeat (2) @(negedge clk);
    force_reset = 1'b0;
    go_idle(30);
    if (got_b0.size() != 0) begin
      other_count++;
      $display("ERROR at %0t: a result appeared for the set cut short by reset", $time);
      got_b0.delete();
      got_b1.delete();
      got_b2.delete();
      got_sing.delete();
      got_cnt.delete();
      got_cyc.delete();
    end
    // the flushed set never pairs with a result
    last_cyc.delete();
    // fresh set, y = -2 + x1 + 4*x2
    k = 0;
    for (int i = 0; i < 8; i++) begin
      put_point(k, grid_x1[i], grid_x2[i], -8, 4, 16);
    end
    stim_n = k;
    send_set();
    go_idle(1);
    await_results(1);
    pop_and_compare(fx_of_int(-2), fx_of_int(1), fx_of_int(4), 1'b0, 1'b1,
                    sample_cnt_t'(8), "set after reset");
  endtask

  // ---------------------------------------------------------------------------
  // main sequence and watchdog
  // ---------------------------------------------------------------------------
  initial begin
    force_reset  = 1'b0;
    sample_valid = 1'b0;
    sample_last  = 1'b0;
    x1           = '0;
    x2           = '0;
    y            = '0;
    void'($urandom(32'hf619));
    wait (rst_n === 1'b1);
    go_idle(2);
    exact_fit();
    pivot_swaps();
    singular_set();
    back_to_back_sets();
    reset_mid_set();
    go_idle(2);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period_ns);
    $display("ERROR: watchdog expired after %0d cycles, the tests did not finish",
             watchdog_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/fx_pkg.sv
verilog/regress_pkg.sv
verilog/fx_mul.sv
verilog/fx_div.sv
verilog/normal_eq_accum.sv
verilog/gauss_eliminate_3x3.sv
verilog/back_substitute_3x3.sv
verilog/regress_top.sv
tb/tb_clkgen.sv
tb/tb_regress.sv

/* run_sim.sh */
#!/bin/sh
# build the regression testbench with Verilator, run it, then grep the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  -f tb.f --top-module tb_regress -Mdir obj_dir > build.log 2>&1 ||
{ cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_regress > sim.log 2>&1
cat sim.log

grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"
